//--- Makefile
# Verilator build for the 6502-style core and its testbench

VERILATOR  ?= verilator
TOP        ?= tb_cpu_core
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --timing
LINT_FLAGS ?= --lint-only
JOBS       ?= 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# The binary exits with a nonzero status on a $fatal, so make fails with it
sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- compile.f
logic/cpu_pkg.sv
logic/instruction_decode.sv
logic/program_counter.sv
logic/bus_interface.sv
logic/alu.sv
logic/status_register.sv
logic/cpu_core_top.sv
verif/tb_cpu_core.sv

//--- logic/alu.sv
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       rdy,
    input  alu_op_t    alu_op,
    input  logic [7:0] idl,
    output logic [7:0] acc,
    output logic [7:0] mem_result,
    output logic [2:0] result_flags
);

    logic [7:0] result;
    logic       carry;

    assign mem_result = {idl[6:0], 1'b0};

    always_comb begin
        result = acc;
        carry  = 1'b0;
        case (alu_op)
            ALU_LOAD: begin
                result = idl;
            end
            ALU_ASL_A: begin
                result = {acc[6:0], 1'b0};
                carry  = acc[7];  // Old bit 7 shifts into carry
            end
            ALU_ASL_MEM: begin
                result = mem_result;
                carry  = idl[7];
            end
            default: begin
                result = acc;
            end
        endcase
    end

    always_comb begin
        result_flags         = 3'b000;
        result_flags[FLAG_C] = carry;
        result_flags[FLAG_Z] = (result == 8'h00);
        result_flags[FLAG_N] = result[7];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc <= 8'h00;
        end else if (rdy && (alu_op == ALU_LOAD || alu_op == ALU_ASL_A)) begin
            acc <= result;
        end
    end

endmodule

//--- logic/bus_interface.sv
`timescale 1ns/1ps

module bus_interface import cpu_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        rdy,
    input  logic        addr_sel,    // 1 selects the zero-page address
    input  logic        zp_load,
    input  latch_mode_t idl_mode,
    input  latch_mode_t dbuf_mode,
    input  logic [15:0] pc,
    input  logic [7:0]  data_in,
    input  logic [7:0]  acc,
    input  logic [7:0]  mem_result,
    output logic [15:0] addr,
    output logic [7:0]  data_out,
    output logic [7:0]  idl
);

    logic [7:0] zp_addr_q;
    logic [7:0] idl_q;
    logic [7:0] dbuf_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            zp_addr_q <= 8'h00;
        end else if (rdy && zp_load) begin
            zp_addr_q <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && idl_mode == BUF_LOAD) begin
            idl_q <= data_in;
        end
        if (rdy && dbuf_mode == BUF_LOAD) begin
            // Shift result during read-modify-write, else the accumulator
            dbuf_q <= (idl_mode == BUF_STORE) ? mem_result : acc;
        end
    end

    assign idl      = (idl_mode == BUF_LOAD) ? data_in : idl_q;  // Transparent while loading
    assign data_out = (dbuf_mode == BUF_STORE) ? dbuf_q : 8'h00;
    assign addr     = addr_sel ? {8'h00, zp_addr_q} : pc;

endmodule

//--- logic/cpu_core_top.sv
`timescale 1ns/1ps

module cpu_core_top import cpu_pkg::*; #(
    parameter logic [15:0] RESET_PC = 16'h0200
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        rdy,
    input  logic [7:0]  data_in,
    output logic [15:0] addr,
    output logic [7:0]  data_out,
    output logic        rw,
    output logic        sync,
    output logic [2:0]  flags
);

    logic        pc_inc;
    logic        addr_sel;
    logic        zp_load;
    latch_mode_t idl_mode;
    latch_mode_t dbuf_mode;
    alu_op_t     alu_op;
    logic [2:0]  flag_mask;
    logic [15:0] pc;
    logic [7:0]  idl;
    logic [7:0]  acc;
    logic [7:0]  mem_result;
    logic [2:0]  result_flags;

    instruction_decode i_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .rdy       (rdy),
        .data_in   (data_in),
        .sync      (sync),
        .pc_inc    (pc_inc),
        .addr_sel  (addr_sel),
        .zp_load   (zp_load),
        .rw        (rw),
        .idl_mode  (idl_mode),
        .dbuf_mode (dbuf_mode),
        .alu_op    (alu_op),
        .flag_mask (flag_mask)
    );

    program_counter #(
        .RESET_PC (RESET_PC)
    ) i_pc (
        .clk    (clk),
        .arst_n (arst_n),
        .rdy    (rdy),
        .pc_inc (pc_inc),
        .pc     (pc)
    );

    bus_interface i_bus (
        .clk        (clk),
        .arst_n     (arst_n),
        .rdy        (rdy),
        .addr_sel   (addr_sel),
        .zp_load    (zp_load),
        .idl_mode   (idl_mode),
        .dbuf_mode  (dbuf_mode),
        .pc         (pc),
        .data_in    (data_in),
        .acc        (acc),
        .mem_result (mem_result),
        .addr       (addr),
        .data_out   (data_out),
        .idl        (idl)
    );

    alu i_alu (
        .clk          (clk),
        .arst_n       (arst_n),
        .rdy          (rdy),
        .alu_op       (alu_op),
        .idl          (idl),
        .acc          (acc),
        .mem_result   (mem_result),
        .result_flags (result_flags)
    );

    status_register i_status (
        .clk          (clk),
        .arst_n       (arst_n),
        .rdy          (rdy),
        .flag_mask    (flag_mask),
        .result_flags (result_flags),
        .flags        (flags)
    );

endmodule

//--- logic/cpu_pkg.sv
package cpu_pkg;

    // Supported opcodes
    localparam logic [7:0] OP_NOP     = 8'hEA;
    localparam logic [7:0] OP_LDA_IMM = 8'hA9;  // Load accumulator, immediate
    localparam logic [7:0] OP_STA_ZPG = 8'h85;  // Store accumulator, zero page
    localparam logic [7:0] OP_ASL_A   = 8'h0A;  // Shift accumulator left
    localparam logic [7:0] OP_ASL_ZPG = 8'h06;  // Shift memory left, read-modify-write

    // Decode FSM states, one per bus cycle of an instruction
    typedef enum logic [2:0] {
        S_RESET,     // Single cycle after reset release
        S_FETCH,     // Opcode read, sync high
        S_OPERAND,   // Second cycle of every instruction
        S_ZPG_READ,  // Zero-page operand read into the input latch
        S_ALU,       // Shift of the latched operand
        S_WRITE      // Bus write cycle
    } decode_state_t;

    typedef enum logic [1:0] {
        ALU_NONE,    // Accumulator holds
        ALU_LOAD,    // Accumulator takes the input latch
        ALU_ASL_A,   // Accumulator shifts left
        ALU_ASL_MEM  // Latched operand shifts left toward the output buffer
    } alu_op_t;

    // Bit positions in the flag vector
    localparam int FLAG_C = 0;
    localparam int FLAG_Z = 1;
    localparam int FLAG_N = 2;

    // Modes shared by the input data latch and the output data buffer
    typedef enum logic [1:0] {
        BUF_IDLE  = 2'b00,
        BUF_LOAD  = 2'b01,
        BUF_STORE = 2'b10
    } latch_mode_t;

endpackage

//--- logic/instruction_decode.sv
`timescale 1ns/1ps

module instruction_decode import cpu_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        rdy,
    input  logic [7:0]  data_in,
    output logic        sync,
    output logic        pc_inc,
    output logic        addr_sel,
    output logic        zp_load,
    output logic        rw,         // 1 for read
    output latch_mode_t idl_mode,
    output latch_mode_t dbuf_mode,
    output alu_op_t     alu_op,
    output logic [2:0]  flag_mask
);

    decode_state_t state_q;
    decode_state_t state_d;
    logic [7:0]    opcode_q;
    logic          known_op;

    // Opcodes this core executes; anything else becomes a NOP
    always_comb begin
        case (data_in)
            OP_NOP, OP_LDA_IMM, OP_STA_ZPG, OP_ASL_A, OP_ASL_ZPG: known_op = 1'b1;
            default: known_op = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= S_RESET;
            opcode_q <= OP_NOP;
        end else if (rdy) begin
            state_q <= state_d;
            if (state_q == S_FETCH) begin
                opcode_q <= known_op ? data_in : OP_NOP;  // Opcode taken straight off the bus
            end
        end
    end

    always_comb begin
        state_d   = state_q;
        sync      = 1'b0;
        pc_inc    = 1'b0;
        addr_sel  = 1'b0;
        zp_load   = 1'b0;
        rw        = 1'b1;
        idl_mode  = BUF_IDLE;
        dbuf_mode = BUF_IDLE;
        alu_op    = ALU_NONE;
        flag_mask = 3'b000;

        case (state_q)
            S_RESET: begin
                state_d = S_FETCH;
            end
            S_FETCH: begin
                sync    = 1'b1;
                pc_inc  = 1'b1;
                state_d = S_OPERAND;
            end
            S_OPERAND: begin
                state_d = S_FETCH;
                case (opcode_q)
                    OP_LDA_IMM: begin
                        pc_inc            = 1'b1;
                        idl_mode          = BUF_LOAD;  // Immediate byte passes to the ALU
                        alu_op            = ALU_LOAD;
                        flag_mask[FLAG_Z] = 1'b1;
                        flag_mask[FLAG_N] = 1'b1;
                    end
                    OP_ASL_A: begin
                        alu_op    = ALU_ASL_A;
                        flag_mask = 3'b111;
                    end
                    OP_STA_ZPG: begin
                        pc_inc    = 1'b1;
                        zp_load   = 1'b1;
                        dbuf_mode = BUF_LOAD;   // Accumulator into the output buffer
                        state_d   = S_WRITE;
                    end
                    OP_ASL_ZPG: begin
                        pc_inc  = 1'b1;
                        zp_load = 1'b1;
                        state_d = S_ZPG_READ;
                    end
                    default: begin
                        state_d = S_FETCH;  // NOP and unknown opcodes
                    end
                endcase
            end
            S_ZPG_READ: begin
                addr_sel = 1'b1;
                idl_mode = BUF_LOAD;
                state_d  = S_ALU;
            end
            S_ALU: begin
                // Read cycle on the same address while the shift happens
                addr_sel  = 1'b1;
                idl_mode  = BUF_STORE;
                dbuf_mode = BUF_LOAD;
                alu_op    = ALU_ASL_MEM;
                flag_mask = 3'b111;
                state_d   = S_WRITE;
            end
            S_WRITE: begin
                addr_sel  = 1'b1;
                rw        = 1'b0;
                dbuf_mode = BUF_STORE;
                state_d   = S_FETCH;
            end
            default: begin
                state_d = S_RESET;
            end
        endcase
    end

endmodule

//--- logic/program_counter.sv
`timescale 1ns/1ps

module program_counter #(
    parameter logic [15:0] RESET_PC = 16'h0200
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        rdy,
    input  logic        pc_inc,
    output logic [15:0] pc
);

    logic [15:0] pc_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q <= RESET_PC;
        end else if (rdy && pc_inc) begin
            pc_q <= pc_q + 16'd1;  // Wraps at 16 bits
        end
    end

    assign pc = pc_q;

endmodule

//--- logic/status_register.sv
`timescale 1ns/1ps

module status_register (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       rdy,
    input  logic [2:0] flag_mask,
    input  logic [2:0] result_flags,
    output logic [2:0] flags
);

    logic [2:0] flags_q;
    logic [2:0] flags_d;

    // Masked bits take the ALU value, the rest keep their state
    assign flags_d = (flags_q & ~flag_mask) | (result_flags & flag_mask);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags_q <= 3'b000;
        end else if (rdy) begin
            flags_q <= flags_d;
        end
    end

    assign flags = flags_q;

endmodule

//--- verif/tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core import cpu_pkg::*; ();

    localparam logic [15:0] RESET_PC    = 16'h0200;
    localparam int          CYCLE_LIMIT = 2000;   // Several times the summed program lengths
    localparam int          RAND_SEED   = 22586;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        rdy;
    logic [7:0]  data_in;
    logic [15:0] addr;
    logic [7:0]  data_out;
    logic        rw;
    logic        sync;
    logic [2:0]  flags;

    logic [7:0]  mem [0:65535];
    int          cycle_count = 0;

    // Program image and the reference results that go with it
    logic [7:0]  prog_q[$];
    logic [2:0]  exp_flags_q[$];
    int          exp_cycles_q[$];
    logic [15:0] exp_wr_addr_q[$];
    logic [7:0]  exp_wr_data_q[$];
    logic [15:0] wr_addr_q[$];        // Writes seen on the bus
    logic [7:0]  wr_data_q[$];
    logic [7:0]  ref_acc;
    logic [2:0]  ref_flags;
    logic [7:0]  ref_zp [0:255];

    // Read-modify-write operands, kept for the stalled rerun
    logic [7:0]  rmw_addr [0:7];
    logic [7:0]  rmw_value [0:7];
    logic [7:0]  rmw_result [0:7];
    logic [2:0]  rmw_flags;

    cpu_core_top #(
        .RESET_PC (RESET_PC)
    ) i_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .rdy      (rdy),
        .data_in  (data_in),
        .addr     (addr),
        .data_out (data_out),
        .rw       (rw),
        .sync     (sync),
        .flags    (flags)
    );

    assign data_in = rw ? mem[addr] : 8'h00;  // Asynchronous read port

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $fatal(1, "Timeout");
        end
    end

    task automatic check(input string name, input logic [15:0] actual,
                         input logic [15:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: actual 0x%h, expected 0x%h", name, actual, expected);
            $display("TB FAILED");
            $fatal(1, "Check failed");
        end
    endtask

    function automatic logic [2:0] with_nz(input logic [2:0] old_flags, input logic [7:0] value);
        logic [2:0] f;
        f         = old_flags;
        f[FLAG_Z] = (value == 8'h00);
        f[FLAG_N] = value[7];
        return f;
    endfunction

    task automatic fill_memory();
        for (int a = 0; a < 65536; a++) begin
            mem[16'(a)] = 8'(a) ^ 8'(a >> 8) ^ 8'h3C;
        end
    endtask

    task automatic start_program();
        prog_q.delete();
        exp_flags_q.delete();
        exp_cycles_q.delete();
        exp_wr_addr_q.delete();
        exp_wr_data_q.delete();
        wr_addr_q.delete();
        wr_data_q.delete();
        ref_acc   = 8'h00;   // Core state right after reset
        ref_flags = 3'b000;
        for (int a = 0; a < 256; a++) begin
            ref_zp[a] = mem[16'(a)];
        end
    endtask

    task automatic lda_imm(input logic [7:0] value);
        prog_q.push_back(OP_LDA_IMM);
        prog_q.push_back(value);
        ref_acc   = value;
        ref_flags = with_nz(ref_flags, value);  // C untouched
        exp_flags_q.push_back(ref_flags);
        exp_cycles_q.push_back(2);
    endtask

    task automatic sta_zpg(input logic [7:0] zp);
        prog_q.push_back(OP_STA_ZPG);
        prog_q.push_back(zp);
        ref_zp[zp] = ref_acc;
        exp_wr_addr_q.push_back({8'h00, zp});
        exp_wr_data_q.push_back(ref_acc);
        exp_flags_q.push_back(ref_flags);
        exp_cycles_q.push_back(3);
    endtask

    task automatic asl_acc();
        prog_q.push_back(OP_ASL_A);
        ref_flags[FLAG_C] = ref_acc[7];
        ref_acc           = {ref_acc[6:0], 1'b0};
        ref_flags         = with_nz(ref_flags, ref_acc);
        exp_flags_q.push_back(ref_flags);
        exp_cycles_q.push_back(2);
    endtask

    task automatic asl_zpg(input logic [7:0] zp);
        logic [7:0] shifted;
        shifted = {ref_zp[zp][6:0], 1'b0};
        prog_q.push_back(OP_ASL_ZPG);
        prog_q.push_back(zp);
        ref_flags[FLAG_C] = ref_zp[zp][7];
        ref_flags         = with_nz(ref_flags, shifted);
        ref_zp[zp]        = shifted;
        exp_wr_addr_q.push_back({8'h00, zp});
        exp_wr_data_q.push_back(shifted);
        exp_flags_q.push_back(ref_flags);
        exp_cycles_q.push_back(5);
    endtask

    // NOP, or an opcode the core does not decode
    task automatic skip_opcode(input logic [7:0] opcode);
        prog_q.push_back(opcode);
        exp_flags_q.push_back(ref_flags);
        exp_cycles_q.push_back(2);
    endtask

    task automatic apply_reset();
        arst_n = 1'b0;
        rdy    = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check("rw", 16'(rw), 16'(1'b1));
            check("sync", 16'(sync), 16'(1'b0));
        end
        arst_n = 1'b1;
    endtask

    task automatic run_program(input bit stall_en);
        int          fetches;
        int          active;
        int          last_fetch;
        bit          stall;
        bit          write_now;
        logic [15:0] load_addr;
        logic [15:0] hold_addr;
        logic        hold_rw;
        logic [7:0]  hold_data;

        load_addr = RESET_PC;
        foreach (prog_q[i]) begin
            mem[load_addr] = prog_q[i];
            load_addr++;
        end
        repeat (4) begin
            mem[load_addr] = OP_NOP;  // Padding after the last instruction
            load_addr++;
        end
        apply_reset();
        fetches    = 0;
        active     = 0;
        last_fetch = 0;
        while (fetches <= exp_cycles_q.size()) begin
            stall = stall_en && ($urandom_range(3) == 0);
            rdy   = !stall;
            if (sync && !stall) begin
                if (fetches == 0) begin
                    check("addr", addr, RESET_PC);
                end else begin
                    check("flags", 16'(flags), 16'(exp_flags_q[fetches - 1]));
                    check("cycles", 16'(active - last_fetch), 16'(exp_cycles_q[fetches - 1]));
                end
                last_fetch = active;
                fetches++;
            end
            hold_addr = addr;
            hold_rw   = rw;
            hold_data = data_out;
            write_now = !rw && !stall;
            @(posedge clk);
            if (write_now) begin
                mem[hold_addr] = hold_data;
                wr_addr_q.push_back(hold_addr);
                wr_data_q.push_back(hold_data);
            end
            @(negedge clk);
            if (stall) begin
                check("addr", addr, hold_addr);  // Frozen bus
                check("rw", 16'(rw), 16'(hold_rw));
            end else begin
                active++;
            end
        end
        rdy = 1'b1;
        check("write count", 16'(wr_addr_q.size()), 16'(exp_wr_addr_q.size()));
        foreach (exp_wr_addr_q[i]) begin
            check("write addr", wr_addr_q[i], exp_wr_addr_q[i]);
            check("write data", 16'(wr_data_q[i]), 16'(exp_wr_data_q[i]));
        end
        for (int a = 0; a < 256; a++) begin
            check($sformatf("mem[%02h]", a), 16'(mem[16'(a)]), 16'(ref_zp[a]));
        end
    endtask

    task automatic reset_sequence();
        apply_reset();
        check("sync", 16'(sync), 16'(1'b0));  // S_RESET cycle
        check("rw", 16'(rw), 16'(1'b1));
        @(negedge clk);
        check("sync", 16'(sync), 16'(1'b1));
        check("addr", addr, RESET_PC);
    endtask

    task automatic load_and_store();
        start_program();
        lda_imm(8'h80);
        asl_acc();  // Sets C so that LDA can be seen to keep it
        repeat (8) begin
            lda_imm(8'($urandom));
            sta_zpg(8'($urandom));
        end
        run_program(1'b0);
    endtask

    task automatic shift_accumulator();
        logic [7:0] values [0:8];
        values[0] = 8'h80;
        values[1] = 8'h00;
        for (int i = 2; i < 9; i++) begin
            values[i] = 8'($urandom);
        end
        start_program();
        for (int i = 0; i < 9; i++) begin
            lda_imm(values[i]);
            asl_acc();
            sta_zpg(8'h10 + 8'(i));
        end
        run_program(1'b0);
        for (int i = 0; i < 9; i++) begin
            check("doubled", 16'(mem[16'h0010 + 16'(i)]), 16'((32'(values[i]) * 2) % 256));
        end
    endtask

    task automatic shift_memory(input bit stall_en);
        if (!stall_en) begin
            for (int i = 0; i < 8; i++) begin
                rmw_addr[i]  = 8'($urandom);
                rmw_value[i] = 8'($urandom);
            end
            rmw_value[0] = 8'h80;
        end
        for (int i = 0; i < 8; i++) begin
            mem[{8'h00, rmw_addr[i]}] = rmw_value[i];
        end
        start_program();
        for (int i = 0; i < 8; i++) begin
            asl_zpg(rmw_addr[i]);
        end
        run_program(stall_en);
        for (int i = 0; i < 8; i++) begin
            if (stall_en) begin
                check("stalled result", 16'(mem[{8'h00, rmw_addr[i]}]), 16'(rmw_result[i]));
            end else begin
                rmw_result[i] = mem[{8'h00, rmw_addr[i]}];
            end
        end
        if (stall_en) begin
            check("stalled flags", 16'(flags), 16'(rmw_flags));
        end else begin
            rmw_flags = flags;
        end
    endtask

    task automatic instruction_timing();
        start_program();
        skip_opcode(OP_NOP);
        skip_opcode(8'hFF);
        lda_imm(8'h40);
        sta_zpg(8'h20);
        asl_zpg(8'h20);
        asl_acc();
        run_program(1'b0);
    endtask

    initial begin
        arst_n = 1'b0;
        rdy    = 1'b1;
        void'($urandom(RAND_SEED));
        fill_memory();
        reset_sequence();
        load_and_store();
        shift_accumulator();
        shift_memory(1'b0);
        instruction_timing();
        shift_memory(1'b1);   // Same operands with random stalls
        $display("TB PASSED");
        $finish;
    end

endmodule
